//--- Makefile
# Verilator flow for the adc_capture testbench

TOP := adc_capture_tb

.PHONY: build run clean

build:
	verilator --binary --timing --assert -f adc_capture.f --top-module $(TOP) \
	  -Mdir obj_dir -o $(TOP)

# the run passes only if the testbench printed the pass line
run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- adc_capture.f
hdl/adc_cfg_pkg.sv
hdl/adc_regs_pkg.sv
hdl/adc_deserialise.sv
hdl/adc_fcsample.sv
hdl/adc_retime.sv
hdl/adc_wb_regs.sv
hdl/adc_capture.sv
sim/tb_clkgen.sv
sim/adc_lane_model.sv
sim/adc_capture_tb.sv

//--- hdl/adc_capture.sv
module adc_capture #(
  parameter int NUM_ADC    = 2,
  parameter int LANES      = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [NUM_ADC*LANES-1:0]                 in_rise,
  input  logic [NUM_ADC*LANES-1:0]                 in_fall,
  input  logic [NUM_ADC-1:0]                       fc_rise,
  input  logic [NUM_ADC-1:0]                       fc_fall,
  input  logic [NUM_ADC-1:0]                       data_rd,
  output adc_cfg_pkg::sample_t [NUM_ADC*LANES-1:0] adc_data,
  output logic [NUM_ADC-1:0]                       adc_dout_vld,
  input  logic                                     wb_cyc,
  input  logic                                     wb_stb,
  input  logic                                     wb_we,
  input  adc_regs_pkg::wb_adr_t                    wb_adr,
  input  adc_regs_pkg::wb_dat_t                    wb_dat_w,
  output adc_regs_pkg::wb_dat_t                    wb_dat_r,
  output logic                                     wb_ack
);

  import adc_cfg_pkg::*;

  sample_t [NUM_ADC*LANES-1:0] par_data;
  fc_hist_t [NUM_ADC-1:0]      fc_sampled;
  logic [NUM_ADC-1:0]          par_vld;
  logic [NUM_ADC-1:0]          fifo_of;
  logic [NUM_ADC-1:0]          fifo_uf;
  logic [NUM_ADC-1:0]          of_clr;
  logic [NUM_ADC-1:0]          uf_clr;
  logic [NUM_ADC-1:0]          cap_en;

  // per chip: deserialiser -> retime fifo, plus the frame clock sampler
  for (genvar g = 0; g < NUM_ADC; g++) begin : g_chip

    adc_deserialise #(
      .LANES (LANES)
    ) adc_deserialise_inst (
      .clk         (clk),
      .rst         (rst),
      .serial_rise (in_rise[g*LANES +: LANES]),
      .serial_fall (in_fall[g*LANES +: LANES]),
      .fclk_rise   (fc_rise[g]),
      .fclk_fall   (fc_fall[g]),
      .pout        (par_data[g*LANES +: LANES]),
      .pvld        (par_vld[g])
    );

    adc_fcsample adc_fcsample_inst (
      .clk        (clk),
      .rst        (rst),
      .fc_rise    (fc_rise[g]),
      .fc_fall    (fc_fall[g]),
      .fc_sampled (fc_sampled[g])
    );

    adc_retime #(
      .LANES      (LANES),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) adc_retime_inst (
      .clk      (clk),
      .rst      (rst),
      .din      (par_data[g*LANES +: LANES]),
      .dvld     (par_vld[g]),
      .cap_en   (cap_en[g]),
      .data_rd  (data_rd[g]),
      .dout     (adc_data[g*LANES +: LANES]),
      .dout_vld (adc_dout_vld[g]),
      .fifo_of  (fifo_of[g]),
      .fifo_uf  (fifo_uf[g]),
      .of_clr   (of_clr[g]),
      .uf_clr   (uf_clr[g])
    );

  end

  adc_wb_regs #(
    .NUM_ADC (NUM_ADC)
  ) adc_wb_regs_inst (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .fc_sampled (fc_sampled),
    .fifo_of    (fifo_of),
    .fifo_uf    (fifo_uf),
    .of_clr     (of_clr),
    .uf_clr     (uf_clr),
    .cap_en     (cap_en)
  );

endmodule

//--- hdl/adc_cfg_pkg.sv
package adc_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // clk cycles per frame, two bits per cycle from the ddr pair
  localparam int FRAME_CYCLES = 6;

  // one sample per lane per frame, msb first
  localparam int SAMPLE_BITS = 2 * FRAME_CYCLES;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one adc sample
  typedef logic [SAMPLE_BITS-1:0] sample_t;

  // frame clock history, oldest bit in the msb
  typedef logic [SAMPLE_BITS-1:0] fc_hist_t;

  // history seen when the sampler is lined up with the frame:
  // high for the first six bits, low for the last six
  localparam fc_hist_t FC_ALIGNED = {
    {FRAME_CYCLES{1'b1}},
    {FRAME_CYCLES{1'b0}}
  };

endpackage

//--- hdl/adc_deserialise.sv
module adc_deserialise #(
  parameter int LANES = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [LANES-1:0]                 serial_rise,
  input  logic [LANES-1:0]                 serial_fall,
  input  logic                             fclk_rise,
  input  logic                             fclk_fall,
  output adc_cfg_pkg::sample_t [LANES-1:0] pout,
  output logic                             pvld
);

  import adc_cfg_pkg::*;

  sample_t [LANES-1:0] shreg;
  logic                fclk_fall_q;
  logic                armed;
  logic                boundary;

  // a new frame starts when the frame clock goes high between two bit pairs,
  // i.e. rise bit high right after a low fall bit
  assign boundary = fclk_rise & ~fclk_fall_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // two bits per cycle, rise bit is the earlier (more significant) one
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      shreg[i] <= {shreg[i][SAMPLE_BITS-3:0], serial_rise[i], serial_fall[i]};
    end
  end

  // at a boundary the shift registers still hold the finished frame
  always_ff @(posedge clk) begin
    if (boundary) begin
      pout <= shreg;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // framing control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      // starts high so a frame clock already high after reset is not
      // taken as a frame start
      fclk_fall_q <= 1'b1;
      armed       <= 1'b0;
      pvld        <= 1'b0;
    end else begin
      fclk_fall_q <= fclk_fall;
      // first boundary only arms, the bits before it are a partial frame
      pvld        <= boundary & armed;
      if (boundary) begin
        armed <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/adc_fcsample.sv
module adc_fcsample (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fc_rise,
  input  logic                  fc_fall,
  output adc_cfg_pkg::fc_hist_t fc_sampled
);

  import adc_cfg_pkg::*;

  // running history of the frame clock, one ddr pair per cycle.
  // software looks at where the ones sit to find the frame phase
  always_ff @(posedge clk) begin
    if (rst) begin
      fc_sampled <= '0;
    end else begin
      // rise bit is older than the fall bit of the same cycle
      fc_sampled <= {fc_sampled[SAMPLE_BITS-3:0], fc_rise, fc_fall};
    end
  end

endmodule

//--- hdl/adc_regs_pkg.sv
package adc_regs_pkg;

  // wishbone widths
  typedef logic [7:0]  wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register map, byte offsets
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // sticky fifo flags, write 1 to clear
  localparam wb_adr_t REG_STATUS = 8'h00;

  // capture enable per chip
  localparam wb_adr_t REG_CTRL = 8'h04;

  // frame clock history of chip n at base + 4*n
  localparam wb_adr_t REG_FC_BASE = 8'h10;

  // status word layout
  localparam int STATUS_OF_LSB = 0;
  localparam int STATUS_UF_LSB = 8;

endpackage

//--- hdl/adc_retime.sv
module adc_retime #(
  parameter int LANES      = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                             clk,
  input  logic                             rst,
  input  adc_cfg_pkg::sample_t [LANES-1:0] din,
  input  logic                             dvld,
  input  logic                             cap_en,
  input  logic                             data_rd,
  output adc_cfg_pkg::sample_t [LANES-1:0] dout,
  output logic                             dout_vld,
  output logic                             fifo_of,
  output logic                             fifo_uf,
  input  logic                             of_clr,
  input  logic                             uf_clr
);

  import adc_cfg_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // one word holds a whole frame, all lanes side by side
  sample_t [LANES-1:0] mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             empty;
  logic             wr_req;
  logic             do_wr;
  logic             do_rd;

  assign full   = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign empty  = (count == '0);
  assign wr_req = dvld & cap_en;
  // no back-pressure toward the adc, a full fifo drops the frame
  assign do_wr  = wr_req & ~full;
  assign do_rd  = data_rd & ~empty;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
    if (do_rd) begin
      dout <= mem[rd_ptr];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers, level and flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      dout_vld <= 1'b0;
      fifo_of  <= 1'b0;
      fifo_uf  <= 1'b0;
    end else begin
      dout_vld <= do_rd;
      // depth is a power of two so the pointers wrap on their own
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // a new event in the clear cycle wins over the clear
      if (wr_req && full) begin
        fifo_of <= 1'b1;
      end else if (of_clr) begin
        fifo_of <= 1'b0;
      end
      if (data_rd && empty) begin
        fifo_uf <= 1'b1;
      end else if (uf_clr) begin
        fifo_uf <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/adc_wb_regs.sv
module adc_wb_regs #(
  parameter int NUM_ADC = 2
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  wb_cyc,
  input  logic                                  wb_stb,
  input  logic                                  wb_we,
  input  adc_regs_pkg::wb_adr_t                 wb_adr,
  input  adc_regs_pkg::wb_dat_t                 wb_dat_w,
  output adc_regs_pkg::wb_dat_t                 wb_dat_r,
  output logic                                  wb_ack,
  input  adc_cfg_pkg::fc_hist_t [NUM_ADC-1:0]   fc_sampled,
  input  logic [NUM_ADC-1:0]                    fifo_of,
  input  logic [NUM_ADC-1:0]                    fifo_uf,
  output logic [NUM_ADC-1:0]                    of_clr,
  output logic [NUM_ADC-1:0]                    uf_clr,
  output logic [NUM_ADC-1:0]                    cap_en
);

  import adc_regs_pkg::*;

  wb_dat_t rd_mux;
  logic    acc;
  logic    status_wr;
  logic    ctrl_wr;

  // one access per strobe, the ack cycle itself is not a new request
  assign acc       = wb_cyc & wb_stb & ~wb_ack;
  assign status_wr = acc & wb_we & (wb_adr == REG_STATUS);
  assign ctrl_wr   = acc & wb_we & (wb_adr == REG_CTRL);

  // write-1-to-clear, the flags drop at the same edge as the ack
  assign of_clr = status_wr ? wb_dat_w[STATUS_OF_LSB +: NUM_ADC] : '0;
  assign uf_clr = status_wr ? wb_dat_w[STATUS_UF_LSB +: NUM_ADC] : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    // unmapped addresses read as zero
    rd_mux = '0;
    if (wb_adr == REG_STATUS) begin
      rd_mux[STATUS_OF_LSB +: NUM_ADC] = fifo_of;
      rd_mux[STATUS_UF_LSB +: NUM_ADC] = fifo_uf;
    end else if (wb_adr == REG_CTRL) begin
      rd_mux[NUM_ADC-1:0] = cap_en;
    end
    for (int i = 0; i < NUM_ADC; i++) begin
      if (wb_adr == wb_adr_t'(REG_FC_BASE + 4 * i)) begin
        rd_mux = wb_dat_t'(fc_sampled[i]);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus response and control register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // read data lands together with the ack
  always_ff @(posedge clk) begin
    if (acc) begin
      wb_dat_r <= rd_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      // all chips capture out of reset
      cap_en <= '1;
    end else begin
      wb_ack <= acc;
      if (ctrl_wr) begin
        cap_en <= wb_dat_w[NUM_ADC-1:0];
      end
    end
  end

endmodule

//--- sim/adc_capture_tb.sv
module adc_capture_tb;

  import adc_cfg_pkg::*;
  import adc_regs_pkg::*;

  localparam int NUM_ADC    = 2;
  localparam int LANES      = 4;
  localparam int FIFO_DEPTH = 8;
  localparam int FRAME_W    = LANES * SAMPLE_BITS;
  localparam int N_FRAMES   = 20;
  // the tests take a few thousand cycles at most
  localparam int MAX_CYCLES = 20000;
  // frame clock history of an aligned frame, six ones then six zeros
  localparam fc_hist_t FC_PATTERN = 12'hfc0;

  logic                        clk;
  logic                        rst = 1'b1;
  wire  [NUM_ADC*LANES-1:0]    in_rise;
  wire  [NUM_ADC*LANES-1:0]    in_fall;
  wire  [NUM_ADC-1:0]          fc_rise;
  wire  [NUM_ADC-1:0]          fc_fall;
  wire  [NUM_ADC-1:0]          lane_idle;
  logic [FRAME_W-1:0]          frame_data [NUM_ADC] = '{default: '0};
  logic [NUM_ADC-1:0]          frame_push = '0;
  logic [NUM_ADC-1:0]          data_rd = '0;
  sample_t [NUM_ADC*LANES-1:0] adc_data;
  logic [NUM_ADC-1:0]          adc_dout_vld;
  logic                        wb_cyc = 1'b0;
  logic                        wb_stb = 1'b0;
  logic                        wb_we = 1'b0;
  wb_adr_t                     wb_adr = '0;
  wb_dat_t                     wb_dat_w = '0;
  wb_dat_t                     wb_dat_r;
  logic                        wb_ack;

  // expected words per chip, in fifo order
  logic [FRAME_W-1:0]          ref_q [NUM_ADC][$];
  logic [FRAME_W-1:0]          exp_word [NUM_ADC];
  logic [NUM_ADC-1:0]          exp_have = '0;

  int    errors = 0;
  int    cycles = 0;
  int    tests_run = 0;
  int    failed_tests = 0;
  int    test_errors = 0;
  string test_name = "reset";

  tb_clkgen #(.PERIOD(100)) clkgen (.clk(clk));

  adc_capture #(
    .NUM_ADC    (NUM_ADC),
    .LANES      (LANES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .in_rise      (in_rise),
    .in_fall      (in_fall),
    .fc_rise      (fc_rise),
    .fc_fall      (fc_fall),
    .data_rd      (data_rd),
    .adc_data     (adc_data),
    .adc_dout_vld (adc_dout_vld),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per chip source and output check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar g = 0; g < NUM_ADC; g++) begin : g_adc

    adc_lane_model #(.LANES(LANES)) lane_model (
      .clk        (clk),
      .rst        (rst),
      .frame_data (frame_data[g]),
      .frame_push (frame_push[g]),
      .ser_rise   (in_rise[g*LANES +: LANES]),
      .ser_fall   (in_fall[g*LANES +: LANES]),
      .fc_rise    (fc_rise[g]),
      .fc_fall    (fc_fall[g]),
      .idle       (lane_idle[g])
    );

    // front of the reference queue, registered so it holds the value of
    // the word the fifo hands out at the next edge
    always @(posedge clk) begin
      if (adc_dout_vld[g] && ref_q[g].size() != 0) begin
        void'(ref_q[g].pop_front());
      end
      exp_have[g] <= (ref_q[g].size() != 0);
      if (ref_q[g].size() != 0) begin
        exp_word[g] <= ref_q[g][0];
      end
    end

    assert property (@(posedge clk) disable iff (rst)
      adc_dout_vld[g] |-> (exp_have[g] && adc_data[g*LANES +: LANES] == exp_word[g]))
    else begin
      errors++;
      if (!$sampled(exp_have[g])) begin
        $display("%s: chip %0d put out a word that was never captured", test_name, g);
      end else begin
        $display("** Error %s: chip %0d expected %h actual %h", test_name, g,
                 $sampled(exp_word[g]), $sampled(adc_data[g*LANES +: LANES]));
      end
    end

  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      failed_tests++;
      $display("test %s: FAILED, %0d errors", test_name, errors - test_errors);
    end
  endtask

  // one classic cycle, held until ack
  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                            output wb_dat_t rdat);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    @(posedge clk);
    while (!wb_ack) begin
      @(posedge clk);
    end
    rdat = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input wb_adr_t adr, input wb_dat_t dat);
    wb_dat_t unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic check_reg(input wb_adr_t adr, input wb_dat_t exp);
    wb_dat_t got;
    bus_access(1'b0, adr, '0, got);
    assert (got == exp) else begin
      errors++;
      $display("** Error %s: reg %h expected %h actual %h", test_name, adr, exp, got);
    end
  endtask

  // queue n random frames on a chip, only the first keep are expected back
  task automatic send_frames(input int chip, input int n, input int keep);
    logic [FRAME_W-1:0] f;
    for (int i = 0; i < n; i++) begin
      for (int l = 0; l < LANES; l++) begin
        f[l*SAMPLE_BITS +: SAMPLE_BITS] = sample_t'($urandom());
      end
      @(posedge clk);
      frame_data[chip] <= f;
      frame_push[chip] <= 1'b1;
      if (i < keep) begin
        ref_q[chip].push_back(f);
      end
    end
    @(posedge clk);
    frame_push[chip] <= 1'b0;
  endtask

  task automatic wait_quiet();
    repeat (2) @(posedge clk);
    while (lane_idle != '1) begin
      @(posedge clk);
    end
    // frame start detect, pvld and fifo write
    repeat (4) @(posedge clk);
  endtask

  task automatic read_words(input int chip, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      data_rd[chip] <= 1'b1;
    end
    @(posedge clk);
    data_rd[chip] <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic check_drained(input int chip);
    assert (ref_q[chip].size() == 0) else begin
      errors++;
      $display("%s: chip %0d is missing %0d words", test_name, chip, ref_q[chip].size());
      ref_q[chip].delete();
    end
  endtask

  function automatic logic is_fc_rotation(input fc_hist_t h);
    fc_hist_t r;
    r = FC_PATTERN;
    for (int i = 0; i < SAMPLE_BITS; i++) begin
      if (h == r) begin
        return 1'b1;
      end
      r = {r[SAMPLE_BITS-2:0], r[SAMPLE_BITS-1]};
    end
    return 1'b0;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    wb_dat_t rdata;
    int      batch;
    void'($urandom(96));
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    begin_test("reset");
    @(posedge clk);
    assert (wb_ack == 1'b0 && adc_dout_vld == '0) else begin
      errors++;
      $display("%s: ack or dout_vld is high after reset", test_name);
    end
    check_reg(REG_STATUS, 32'h0);
    check_reg(REG_CTRL, wb_dat_t'((1 << NUM_ADC) - 1));
    end_test();

    // the first frame after reset only lines up the deserialiser
    for (int n = 0; n < NUM_ADC; n++) begin
      send_frames(n, 1, 0);
    end
    wait_quiet();

    // history is read while both chips are streaming a fifo's worth of frames
    begin_test("fc_readback");
    for (int n = 0; n < NUM_ADC; n++) begin
      send_frames(n, FIFO_DEPTH, FIFO_DEPTH);
    end
    repeat (2 * FRAME_CYCLES) @(posedge clk);
    for (int n = 0; n < NUM_ADC; n++) begin
      bus_access(1'b0, wb_adr_t'(REG_FC_BASE + 4 * n), '0, rdata);
      assert (rdata[31:SAMPLE_BITS] == '0 && is_fc_rotation(rdata[SAMPLE_BITS-1:0]))
      else begin
        errors++;
        $display("** Error %s: chip %0d expected a rotation of %h actual %h",
                 test_name, n, FC_PATTERN, rdata);
      end
    end
    end_test();

    begin_test("data_integrity");
    wait_quiet();
    for (int n = 0; n < NUM_ADC; n++) begin
      read_words(n, FIFO_DEPTH);
    end
    // the remaining frames go in batches that fit the fifo
    for (int left = N_FRAMES - FIFO_DEPTH; left > 0; left -= batch) begin
      batch = (left < FIFO_DEPTH) ? left : FIFO_DEPTH;
      for (int n = 0; n < NUM_ADC; n++) begin
        send_frames(n, batch, batch);
      end
      wait_quiet();
      for (int n = 0; n < NUM_ADC; n++) begin
        read_words(n, batch);
      end
    end
    for (int n = 0; n < NUM_ADC; n++) begin
      check_drained(n);
    end
    end_test();

    begin_test("overflow");
    send_frames(0, FIFO_DEPTH + 3, FIFO_DEPTH);
    wait_quiet();
    check_reg(REG_STATUS, 32'h0000_0001);
    read_words(0, FIFO_DEPTH);
    check_drained(0);
    write_reg(REG_STATUS, 32'h0000_0001);
    check_reg(REG_STATUS, 32'h0);
    end_test();

    begin_test("underflow");
    read_words(1, 1);
    check_reg(REG_STATUS, 32'h0000_0200);
    write_reg(REG_STATUS, 32'h0000_0200);
    check_reg(REG_STATUS, 32'h0);
    end_test();

    begin_test("capture_enable");
    write_reg(REG_CTRL, 32'h1);
    check_reg(REG_CTRL, 32'h1);
    send_frames(0, 5, 5);
    send_frames(1, 5, 0);
    wait_quiet();
    read_words(0, 5);
    check_drained(0);
    // chip 1 has to be empty, so this read only raises its underflow flag
    read_words(1, 1);
    check_reg(REG_STATUS, 32'h0000_0200);
    write_reg(REG_STATUS, 32'h0000_0200);
    write_reg(REG_CTRL, wb_dat_t'((1 << NUM_ADC) - 1));
    send_frames(1, 5, 5);
    wait_quiet();
    read_words(1, 5);
    check_drained(1);
    check_reg(REG_STATUS, 32'h0);
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sim/adc_lane_model.sv
module adc_lane_model #(
  parameter int LANES = 4
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic [LANES*adc_cfg_pkg::SAMPLE_BITS-1:0] frame_data,
  input  logic                                      frame_push,
  output logic [LANES-1:0]                          ser_rise,
  output logic [LANES-1:0]                          ser_fall,
  output logic                                      fc_rise,
  output logic                                      fc_fall,
  output logic                                      idle
);

  import adc_cfg_pkg::*;

  localparam int FRAME_W = LANES * SAMPLE_BITS;

  logic [FRAME_W-1:0] frame_q[$];
  logic [FRAME_W-1:0] cur = '0;
  int                 phase = 0;
  logic               sending = 1'b0;

  // between bursts the frame clock rests high, so the deserialiser sees a
  // frame start only once a whole frame has gone by
  logic [LANES-1:0]   rise_q = '0;
  logic [LANES-1:0]   fall_q = '0;
  logic               fc_rise_q = 1'b1;
  logic               fc_fall_q = 1'b1;
  logic               idle_q = 1'b1;

  assign ser_rise = rise_q;
  assign ser_fall = fall_q;
  assign fc_rise  = fc_rise_q;
  assign fc_fall  = fc_fall_q;
  assign idle     = idle_q;

  always @(posedge clk) begin
    if (frame_push) begin
      frame_q.push_back(frame_data);
    end
    if (rst) begin
      phase = 0;
      sending = 1'b0;
      rise_q    <= '0;
      fall_q    <= '0;
      fc_rise_q <= 1'b1;
      fc_fall_q <= 1'b1;
    end else begin
      if (phase == 0) begin
        sending = (frame_q.size() != 0);
        if (sending) begin
          cur = frame_q.pop_front();
        end
      end
      if (sending) begin
        // msb first, the rise bit of a pair is the earlier one
        for (int l = 0; l < LANES; l++) begin
          rise_q[l] <= cur[l*SAMPLE_BITS + SAMPLE_BITS - 1 - 2*phase];
          fall_q[l] <= cur[l*SAMPLE_BITS + SAMPLE_BITS - 2 - 2*phase];
        end
        fc_rise_q <= (phase < FRAME_CYCLES / 2);
        fc_fall_q <= (phase < FRAME_CYCLES / 2);
        phase = (phase + 1) % FRAME_CYCLES;
      end else begin
        rise_q    <= '0;
        fall_q    <= '0;
        fc_rise_q <= 1'b1;
        fc_fall_q <= 1'b1;
      end
    end
    idle_q <= (phase == 0) && (frame_q.size() == 0);
  end

endmodule

//--- sim/tb_clkgen.sv
module tb_clkgen #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // free running, 50% duty
  always #(PERIOD / 2) clk = ~clk;

endmodule
